// File: all.f
+incdir+common
common/ej_isa_pkg.sv
common/ej_ctl_pkg.sv
design/ej_fetch.sv
branch/ej_branch.sv
design/ej_stack.sv
design/ej_trace.sv
design/ej_top.sv
test/ej_assertions.sv
test/ej_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= ej_tb
FLIST     ?= all.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

$(BUILD)/V$(TOP): $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	test $$status -eq 0 && ! grep -q "Simulation FAILED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: test/ej_tb.sv
// ==============================
// testbench: random programs, reference
// model, retire checks, watchdog
// ==============================
`include "ej_config.svh"

module ej_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_TESTS  = 8;
    localparam int N_RET    = 40;   // retires checked per test
    localparam int PLEN_MAX = 64;   // program bytes per test
    // 4 cycles per op, x3 for pauses, plus the memory fill and resets
    localparam longint WD_NS = (64'd4096 + N_TESTS * (80 + N_RET * 4 * 3)) * 20 + 10000;

    logic            ctl, rst, run, prog_we;
    logic [`ASZ-1:0] prog_addr;
    logic [7:0]      prog_data;
    logic            retire;
    logic [`ASZ-1:0] retire_pc;
    logic [7:0]      retire_op;
    logic [`DSZ-1:0] tos, rtop;

    integer seed;
    int     err_cnt, chk_cnt;
    logic [7:0] img [1 << `ASZ];    // mirror of program RAM
    logic [7:0] prog [PLEN_MAX];
    int         plen;

    // reference machine state
    logic [`ASZ-1:0]              m_pc;
    logic [`DSZ-1:0]              m_t;
    logic [`DSZ-1:0]              m_ss [`DS_DEPTH];
    logic [$clog2(`DS_DEPTH)-1:0] m_sp;
    logic [`DSZ-1:0]              m_rs [`RS_DEPTH];
    logic [$clog2(`RS_DEPTH)-1:0] m_rp;

    logic [7:0] op_table [18] = '{
        ej_isa_pkg::op_nop, ej_isa_pkg::op_bipush, ej_isa_pkg::op_pop,
        ej_isa_pkg::op_dup, ej_isa_pkg::op_iadd, ej_isa_pkg::op_isub,
        ej_isa_pkg::op_ifeq, ej_isa_pkg::op_ifne, ej_isa_pkg::op_iflt,
        ej_isa_pkg::op_if_icmpeq, ej_isa_pkg::op_if_icmplt, ej_isa_pkg::op_goto,
        ej_isa_pkg::op_return, ej_isa_pkg::op_invokevirtual, ej_isa_pkg::op_donext,
        ej_isa_pkg::op_pushr, ej_isa_pkg::op_popr, ej_isa_pkg::op_dupr
    };

    ej_top u_dut (
        .ctl(ctl), .rst(rst), .run(run),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .retire(retire), .retire_pc(retire_pc), .retire_op(retire_op),
        .tos(tos), .rtop(rtop)
    );

    initial begin
        ctl = 1'b0;
        forever #10 ctl = ~ctl;    // 20 ns period
    end

    function automatic int rnd(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    // instruction length in bytes, opcode included
    function automatic int byte_len(input logic [7:0] b);
        case (b)
        ej_isa_pkg::op_bipush: return 2;
        ej_isa_pkg::op_ifeq, ej_isa_pkg::op_ifne, ej_isa_pkg::op_iflt,
        ej_isa_pkg::op_if_icmpeq, ej_isa_pkg::op_if_icmplt, ej_isa_pkg::op_goto,
        ej_isa_pkg::op_invokevirtual, ej_isa_pkg::op_donext: return 3;
        default: return 1;
        endcase
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic write_byte(input logic [`ASZ-1:0] ad, input logic [7:0] d);
        @(posedge ctl);
        prog_we   <= 1'b1;
        prog_addr <= ad;
        prog_data <= d;
        img[ad] = d;
    endtask

    function automatic void dpush(input logic [`DSZ-1:0] v);
        m_sp       = m_sp + 1'b1;
        m_ss[m_sp] = m_t;          // old top goes under
        m_t        = v;
    endfunction

    function automatic void dpop();
        m_t  = m_ss[m_sp];
        m_sp = m_sp - 1'b1;
    endfunction

    function automatic void rpush(input logic [`DSZ-1:0] v);
        m_rp       = m_rp + 1'b1;
        m_rs[m_rp] = v;
    endfunction

    function automatic void model_reset();
        m_pc = '0;
        m_t  = '0;
        m_sp = '0;
        m_rp = '0;
        for (int i = 0; i < `DS_DEPTH; i++) m_ss[i] = '0;
        for (int i = 0; i < `RS_DEPTH; i++) m_rs[i] = '0;
    endfunction

    // one instruction at m_pc, reports its address and opcode
    task automatic model_step(output logic [`ASZ-1:0] pc, output logic [7:0] op);
        logic [7:0]      b, b1;
        logic [`ASZ-1:0] a1, a2, nxt, tg;
        logic [`DSZ-1:0] d, r;
        b   = img[m_pc];
        a1  = m_pc + 1'b1;
        a2  = m_pc + 2'd2;
        b1  = img[a1];
        tg  = {b1[`ASZ-9:0], img[a2]};  // hi byte first
        nxt = m_pc + `ASZ'(byte_len(b));
        r   = m_rs[m_rp];
        pc  = m_pc;
        op  = b;
        case (b)
        ej_isa_pkg::op_bipush: dpush({{(`DSZ-8){b1[7]}}, b1});
        ej_isa_pkg::op_dup:    dpush(m_t);
        ej_isa_pkg::op_pop:    dpop();
        ej_isa_pkg::op_iadd: begin
            d = m_ss[m_sp] + m_t;
            dpop();
            m_t = d;
        end
        ej_isa_pkg::op_isub: begin
            d = m_ss[m_sp] - m_t;
            dpop();
            m_t = d;
        end
        ej_isa_pkg::op_ifeq: begin
            if (m_t == '0) nxt = tg;
            dpop();
        end
        ej_isa_pkg::op_ifne: begin
            if (m_t != '0) nxt = tg;
            dpop();
        end
        ej_isa_pkg::op_iflt: begin
            if (m_t[`DSZ-1]) nxt = tg;
            dpop();
        end
        ej_isa_pkg::op_if_icmpeq, ej_isa_pkg::op_if_icmplt: begin
            d = m_ss[m_sp] - m_t;  // value1 - value2
            dpop();
            dpop();
            if (b == ej_isa_pkg::op_if_icmpeq ? (d == '0) : d[`DSZ-1]) nxt = tg;
        end
        ej_isa_pkg::op_goto: nxt = tg;
        ej_isa_pkg::op_invokevirtual: begin
            rpush(`DSZ'(nxt));   // call addr + 3
            nxt = tg;
        end
        ej_isa_pkg::op_return: begin
            nxt  = r[`ASZ-1:0];
            m_rp = m_rp - 1'b1;
        end
        ej_isa_pkg::op_donext: begin
            if (r == '0) begin
                m_rp = m_rp - 1'b1;    // count used up
            end else begin
                m_rs[m_rp] = r - 1'b1;
                nxt        = tg;
            end
        end
        ej_isa_pkg::op_pushr: begin
            rpush(m_t);
            dpop();
        end
        ej_isa_pkg::op_popr: begin
            dpush(r);
            m_rp = m_rp - 1'b1;
        end
        ej_isa_pkg::op_dupr: dpush(r);
        default: ;
        endcase
        m_pc = nxt;
    endtask

    // random valid program, ends in goto 0, targets on instruction starts
    task automatic gen_program();
        int              pos;
        int              starts[$];
        int              fix[$];
        logic [7:0]      op;
        logic [`ASZ-1:0] tg;
        pos = 0;
        while (pos < PLEN_MAX - 6) begin
            starts.push_back(pos);
            op = op_table[rnd(18)];
            if (op == ej_isa_pkg::op_pushr) begin
                prog[pos]     = ej_isa_pkg::op_bipush;  // small loop count first
                prog[pos + 1] = 8'(rnd(4));
                prog[pos + 2] = op;
                starts.push_back(pos + 2);
                pos += 3;
            end else begin
                prog[pos] = op;
                if (byte_len(op) == 2) prog[pos + 1] = 8'(rnd(256));
                if (byte_len(op) == 3) fix.push_back(pos);
                pos += byte_len(op);
            end
        end
        prog[pos]     = ej_isa_pkg::op_goto;
        prog[pos + 1] = 8'h00;
        prog[pos + 2] = 8'h00;
        plen = pos + 3;
        foreach (fix[i]) begin
            tg               = `ASZ'(starts[rnd(starts.size())]);
            prog[fix[i] + 1] = 8'(tg >> 8);
            prog[fix[i] + 2] = tg[7:0];
        end
    endtask

    task automatic run_test(input int n, input bit pausing);
        int              got, err0;
        logic [`ASZ-1:0] e_pc;
        logic [7:0]      e_op;
        err0 = err_cnt;
        @(posedge ctl);
        rst <= 1'b1;
        repeat (10) @(posedge ctl);
        rst <= 1'b0;
        gen_program();
        for (int i = 0; i < plen; i++) write_byte(`ASZ'(i), prog[i]);
        @(posedge ctl);
        prog_we <= 1'b0;
        model_reset();
        @(posedge ctl);
        run <= 1'b1;
        got = 0;
        while (got < N_RET) begin
            @(posedge ctl);
            if (retire) begin
                model_step(e_pc, e_op);
                check("retire_pc", 32'(retire_pc), 32'(e_pc));
                check("retire_op", 32'(retire_op), 32'(e_op));
                check("tos", tos, m_t);
                check("rtop", rtop, m_rs[m_rp]);
                got++;
            end
            if (pausing) begin
                if (run && rnd(12) == 0) run <= 1'b0;      // random stall
                else if (!run && rnd(3) == 0) run <= 1'b1;
            end
        end
        @(posedge ctl);
        run <= 1'b0;
        $display("test %0d%s: %0d retires, %0d errors", n, pausing ? " with pauses" : "",
                 got, err_cnt - err0);
    endtask

    initial begin
        seed      = 32'he59b8e57;
        rst       = 1'b1;
        run       = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        err_cnt   = 0;
        chk_cnt   = 0;
        // whole RAM gets a known pattern, stray returns land on defined bytes
        for (int i = 0; i < (1 << `ASZ); i++) begin
            write_byte(`ASZ'(i), 8'(i) ^ {4'(i >> 8), 4'(i >> 8)});
        end
        for (int n = 0; n < N_TESTS; n++) run_test(n, n % 2 == 1);
        $display("tests %0d, checks %0d, errors %0d", N_TESTS, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(WD_NS * 1ns);
        $display("timeout: the core stopped retiring instructions");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: test/ej_assertions.sv
// ==============================
// bound checks on the branch unit
// ==============================
`include "ej_config.svh"

module ej_assertions (
    input logic            ctl,
    input logic            rst,
    input logic            run,
    input logic            op_start,
    input logic            op_done,
    input logic            asel,
    input logic [1:0]      phase,
    input logic [`ASZ-1:0] p,
    input logic [`ASZ-1:0] a,
    input logic [`ASZ-1:0] op_pc
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [`ASZ-1:0] fetch_addr;  // byte address the fetch unit reads

    assign fetch_addr = asel ? a : p;

    // a commit that really took effect leaves the FSM back in phase 0
    done_needs_run: assert property (@(posedge ctl) disable iff (rst)
        op_done |=> phase == 2'd0)
        else $error("op_done fired while the core was frozen");

    // opcode address handed to the trace is the one the fetch used
    fetch_mux: assert property (@(posedge ctl) disable iff (rst)
        (run && phase == 2'd0) |=> (phase == 2'd1 && op_pc == $past(fetch_addr)))
        else $error("opcode address differs from the P/A mux address");

    start_single: assert property (@(posedge ctl) disable iff (rst) op_start |=> !op_start)
        else $error("op_start held for two cycles");

endmodule

bind ej_branch ej_assertions u_assert (
    .ctl(ctl), .rst(rst), .run(run), .op_start(op_start), .op_done(op_done),
    .asel(asel), .phase(phase), .p(p), .a(a), .op_pc(op_pc)
);

// File: design/ej_top.sv
// ==============================
// core top: fetch, branch unit,
// data stack, trace
// ==============================
`include "ej_config.svh"

module ej_top (
    input  logic            ctl,
    input  logic            rst,
    input  logic            run,
    input  logic            prog_we,
    input  logic [`ASZ-1:0] prog_addr,
    input  logic [7:0]      prog_data,
    output logic            retire,
    output logic [`ASZ-1:0] retire_pc,
    output logic [7:0]      retire_op,
    output logic [`DSZ-1:0] tos,
    output logic [`DSZ-1:0] rtop
);

    logic [`ASZ-1:0]     p, a, op_pc;
    logic                asel, t_z, t_neg;
    logic [7:0]          data, op_code;
    ej_ctl_pkg::stk_op_t ds_op;
    ej_ctl_pkg::alu_op_t alu_op;
    logic [`DSZ-1:0]     t_in, t, s;
    logic [`DSZ-1:0]     rs_top;  // live return stack top
    logic                op_start, op_done;

    // input side
    ej_fetch u_fetch (
        .ctl(ctl), .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .run(run), .p(p), .a(a), .asel(asel), .data(data)
    );

    // sequencing and return stack
    ej_branch u_branch (
        .ctl(ctl), .rst(rst), .run(run), .data(data),
        .t(t), .s(s), .t_z(t_z), .t_neg(t_neg),
        .p(p), .a(a), .asel(asel),
        .ds_op(ds_op), .alu_op(alu_op), .t_in(t_in), .rtop(rs_top),
        .op_start(op_start), .op_pc(op_pc), .op_code(op_code), .op_done(op_done)
    );

    ej_stack u_stack (
        .ctl(ctl), .rst(rst), .run(run),
        .ds_op(ds_op), .alu_op(alu_op), .t_in(t_in),
        .t(t), .s(s), .t_z(t_z), .t_neg(t_neg)
    );

    // output side
    ej_trace u_trace (
        .ctl(ctl), .rst(rst),
        .op_start(op_start), .op_pc(op_pc), .op_code(op_code), .op_done(op_done),
        .t(t), .rtop(rs_top),
        .retire(retire), .retire_pc(retire_pc), .retire_op(retire_op),
        .tos(tos), .rtop_out(rtop)
    );

endmodule

// File: design/ej_trace.sv
// ==============================
// retire trace: pc, opcode and
// committed stack tops
// ==============================
`include "ej_config.svh"

module ej_trace (
    input  logic            ctl,
    input  logic            rst,
    input  logic            op_start,
    input  logic [`ASZ-1:0] op_pc,
    input  logic [7:0]      op_code,
    input  logic            op_done,
    input  logic [`DSZ-1:0] t,
    input  logic [`DSZ-1:0] rtop,
    output logic            retire,
    output logic [`ASZ-1:0] retire_pc,
    output logic [7:0]      retire_op,
    output logic [`DSZ-1:0] tos,
    output logic [`DSZ-1:0] rtop_out
);

    logic [`ASZ-1:0] pc_l;    // start address of op in flight
    logic [7:0]      op_l;
    logic            done_d;  // commit now visible on t and rtop

    always_ff @(posedge ctl) begin
        if (op_start) begin
            pc_l <= op_pc;
            op_l <= op_code;
        end
    end

    always_ff @(posedge ctl) begin
        if (rst) begin
            done_d <= 1'b0;
            retire <= 1'b0;
        end else begin
            done_d <= op_done;
            retire <= done_d;  // one strobe per instruction
        end
    end

    // sampled together with the strobe
    always_ff @(posedge ctl) begin
        if (done_d) begin
            retire_pc <= pc_l;
            retire_op <= op_l;
            tos       <= t;
            rtop_out  <= rtop;
        end
    end

endmodule

// File: design/ej_stack.sv
// ==============================
// data stack: TOS reg, NOS ring,
// ALU and flags
// ==============================
`include "ej_config.svh"

module ej_stack (
    input  logic                ctl,
    input  logic                rst,
    input  logic                run,
    input  ej_ctl_pkg::stk_op_t ds_op,
    input  ej_ctl_pkg::alu_op_t alu_op,
    input  logic [`DSZ-1:0]     t_in,
    output logic [`DSZ-1:0]     t,
    output logic [`DSZ-1:0]     s,
    output logic                t_z,
    output logic                t_neg
);

    logic [`DSZ-1:0]              ss [`DS_DEPTH];  // entries below TOS
    logic [$clog2(`DS_DEPTH)-1:0] sp, sp1;
    logic [`DSZ-1:0]              t_n;

    assign s     = ss[sp];
    assign sp1   = sp + 1'b1;
    assign t_z   = (t == '0);
    assign t_neg = t[`DSZ-1];  // sign bit

    // new TOS candidate, wraps at 32 bits
    always_comb begin
        case (alu_op)
        ej_ctl_pkg::a_add: t_n = s + t;
        ej_ctl_pkg::a_sub: t_n = s - t;
        default:           t_n = t_in;
        endcase
    end

    always_ff @(posedge ctl) begin
        if (rst) begin
            t  <= '0;
            sp <= '0;
            for (int i = 0; i < `DS_DEPTH; i++) begin
                ss[i] <= '0;
            end
        end else if (run) begin
            case (ds_op)
            ej_ctl_pkg::s_push: begin
                ss[sp1] <= t;   // old TOS becomes NOS
                sp      <= sp1;
                t       <= t_n;
            end
            ej_ctl_pkg::s_pop: begin
                sp <= sp - 1'b1;
                t  <= t_n;      // s or ALU result
            end
            ej_ctl_pkg::s_move: t <= t_n;
            default: ;
            endcase
        end
    end

endmodule

// File: branch/ej_branch.sv
// ==============================
// branching unit: phase FSM, PC,
// address reg, return stack
// ==============================
`include "ej_config.svh"

module ej_branch (
    input  logic                ctl,
    input  logic                rst,
    input  logic                run,
    input  logic [7:0]          data,
    input  logic [`DSZ-1:0]     t,
    input  logic [`DSZ-1:0]     s,
    input  logic                t_z,
    input  logic                t_neg,
    output logic [`ASZ-1:0]     p,
    output logic [`ASZ-1:0]     a,
    output logic                asel,
    output ej_ctl_pkg::stk_op_t ds_op,
    output ej_ctl_pkg::alu_op_t alu_op,
    output logic [`DSZ-1:0]     t_in,
    output logic [`DSZ-1:0]     rtop,
    output logic                op_start,
    output logic [`ASZ-1:0]     op_pc,
    output logic [7:0]          op_code,
    output logic                op_done
);

    logic [1:0]                    phase, phase_n;  // 0 fetch, 1 opcode, 2..3 operands
    ej_isa_pkg::opcode_t           code, op;
    logic [1:0]                    len;
    logic                          commit;          // last phase of this op
    logic [`ASZ-1:0]               p_n, a_n, a_d, tgt;
    logic                          asel_n, jmp, take;
    logic [`DSZ-1:0]               rs [`RS_DEPTH];
    logic [$clog2(`RS_DEPTH)-1:0]  rp, rp1;
    ej_ctl_pkg::stk_op_t           rs_op;
    logic [`DSZ-1:0]               r_n;

    assign rtop = rs[rp];
    assign rp1  = rp + 1'b1;
    assign a_d  = {a[`ASZ-9:0], data};  // hi byte shifted up, lo byte merged
    // opcode is still on the bus in phase 1, registered afterwards
    assign op     = (phase == 2'd1) ? ej_isa_pkg::opcode_t'(data) : code;
    assign len    = ej_isa_pkg::op_len(op);
    assign commit = (phase == len);

    assign op_start = run && (phase == 2'd1);
    assign op_code  = data;
    assign op_pc    = p - 1'b1;  // p already stepped past the opcode

    // branch conditions, only looked at in the commit phase
    always_comb begin
        case (code)
        ej_isa_pkg::op_ifeq, ej_isa_pkg::op_if_icmpeq: take = t_z;
        ej_isa_pkg::op_ifne:                           take = !t_z;
        ej_isa_pkg::op_iflt, ej_isa_pkg::op_if_icmplt: take = t_neg;
        default:                                       take = 1'b0;
        endcase
    end

    always_comb begin
        phase_n = 2'd0;
        p_n     = p;
        a_n     = a;
        asel_n  = 1'b0;
        ds_op   = ej_ctl_pkg::s_nop;
        alu_op  = ej_ctl_pkg::a_load;
        t_in    = s;                    // plain pop brings NOS up
        rs_op   = ej_ctl_pkg::s_nop;
        r_n     = rtop;
        op_done = 1'b0;
        jmp     = 1'b0;
        tgt     = a_d;
        if (phase == 2'd0) begin
            phase_n = 2'd1;
            p_n     = (asel ? a : p) + 1'b1;  // same mux as fetch
        end else begin
            if (commit) begin
                op_done = run;
            end else begin
                phase_n = phase + 2'd1;
                p_n     = p + 1'b1;     // walk operand bytes
                if (phase == 2'd2) begin
                    a_n = {{(`ASZ-8){1'b0}}, data};  // target hi byte
                end
            end
            case (op)
            ej_isa_pkg::op_bipush: begin
                if (commit) begin
                    ds_op = ej_ctl_pkg::s_push;
                    t_in  = {{(`DSZ-8){data[7]}}, data};  // sign extended
                end
            end
            ej_isa_pkg::op_dup: begin
                ds_op = ej_ctl_pkg::s_push;
                t_in  = t;
            end
            ej_isa_pkg::op_pop:  ds_op = ej_ctl_pkg::s_pop;
            ej_isa_pkg::op_iadd: begin
                ds_op  = ej_ctl_pkg::s_pop;
                alu_op = ej_ctl_pkg::a_add;
            end
            ej_isa_pkg::op_isub: begin
                ds_op  = ej_ctl_pkg::s_pop;
                alu_op = ej_ctl_pkg::a_sub;
            end
            ej_isa_pkg::op_ifeq, ej_isa_pkg::op_ifne, ej_isa_pkg::op_iflt: begin
                if (commit) begin
                    ds_op = ej_ctl_pkg::s_pop;  // tested value always dropped
                    jmp   = take;
                end
            end
            ej_isa_pkg::op_if_icmpeq, ej_isa_pkg::op_if_icmplt: begin
                if (phase == 2'd2) begin
                    ds_op  = ej_ctl_pkg::s_pop;  // t <= s - t, flags follow
                    alu_op = ej_ctl_pkg::a_sub;
                end else if (commit) begin
                    ds_op = ej_ctl_pkg::s_pop;   // drop the difference
                    jmp   = take;
                end
            end
            ej_isa_pkg::op_goto: jmp = commit;
            ej_isa_pkg::op_invokevirtual: begin
                if (commit) begin
                    rs_op = ej_ctl_pkg::s_push;
                    r_n   = {{(`DSZ-`ASZ){1'b0}}, p};  // opcode addr + 3
                    jmp   = 1'b1;
                end
            end
            ej_isa_pkg::op_return: begin
                rs_op = ej_ctl_pkg::s_pop;
                jmp   = 1'b1;
                tgt   = rtop[`ASZ-1:0];
            end
            ej_isa_pkg::op_donext: begin
                if (commit && rtop == '0) begin
                    rs_op = ej_ctl_pkg::s_pop;   // loop done, fall through
                end else if (commit) begin
                    rs_op = ej_ctl_pkg::s_move;
                    r_n   = rtop - 1'b1;
                    jmp   = 1'b1;
                end
            end
            ej_isa_pkg::op_pushr: begin
                ds_op = ej_ctl_pkg::s_pop;
                rs_op = ej_ctl_pkg::s_push;
                r_n   = t;
            end
            ej_isa_pkg::op_popr: begin
                ds_op = ej_ctl_pkg::s_push;
                t_in  = rtop;
                rs_op = ej_ctl_pkg::s_pop;
            end
            ej_isa_pkg::op_dupr: begin
                ds_op = ej_ctl_pkg::s_push;
                t_in  = rtop;
            end
            default: ;  // nop and unknown bytes
            endcase
        end
        // taken jump goes through a, next fetch reads from there
        if (jmp) begin
            a_n    = tgt;
            asel_n = 1'b1;
        end
    end

    always_ff @(posedge ctl) begin
        if (rst) begin
            phase <= 2'd0;
            p     <= '0;
            a     <= '0;
            asel  <= 1'b0;
            code  <= ej_isa_pkg::op_nop;
        end else if (run) begin
            phase <= phase_n;
            p     <= p_n;
            a     <= a_n;
            asel  <= asel_n;
            if (op_start) begin
                code <= op;
            end
        end
    end

    // circular return stack, top at rs[rp]
    always_ff @(posedge ctl) begin
        if (rst) begin
            rp <= '0;
            for (int i = 0; i < `RS_DEPTH; i++) begin
                rs[i] <= '0;
            end
        end else if (run) begin
            case (rs_op)
            ej_ctl_pkg::s_push: begin
                rs[rp1] <= r_n;
                rp      <= rp1;
            end
            ej_ctl_pkg::s_pop:  rp <= rp - 1'b1;
            ej_ctl_pkg::s_move: rs[rp] <= r_n;
            default: ;
            endcase
        end
    end

endmodule

// File: design/ej_fetch.sv
// ==============================
// program byte RAM, load port,
// P/A address mux
// ==============================
`include "ej_config.svh"

module ej_fetch (
    input  logic            ctl,
    input  logic            prog_we,
    input  logic [`ASZ-1:0] prog_addr,
    input  logic [7:0]      prog_data,
    input  logic            run,
    input  logic [`ASZ-1:0] p,
    input  logic [`ASZ-1:0] a,
    input  logic            asel,
    output logic [7:0]      data
);

    logic [7:0]      mem [1 << `ASZ];  // whole program space
    logic [`ASZ-1:0] addr;

    // address reg only when branch unit asks for it
    assign addr = asel ? a : p;

    // loader owns the RAM while halted
    always_ff @(posedge ctl) begin
        if (!run && prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // registered read, held during pause so operand bytes survive
    always_ff @(posedge ctl) begin
        if (run) begin
            data <= mem[addr];  // byte shows up next cycle
        end
    end

endmodule

// File: common/ej_ctl_pkg.sv
// ==============================
// control codes between branch
// unit and stacks
// ==============================
package ej_ctl_pkg;

    // stack pointer action, shared by data and return stack
    typedef enum logic [1:0] {
        s_nop,     // hold
        s_push,    // old top moves down
        s_pop,     // entry below comes up
        s_move     // top rewritten in place
    } stk_op_t;

    // source of the new TOS value
    typedef enum logic [1:0] {
        a_load,    // t_in from branch unit
        a_add,     // s + t
        a_sub      // s - t, also used for compares
    } alu_op_t;

endpackage

// File: common/ej_isa_pkg.sv
// ==============================
// bytecode subset and operand
// length per opcode
// ==============================
package ej_isa_pkg;

    // encodings follow the JVM, donext and friends live in the free 0xca range
    typedef enum logic [7:0] {
        op_nop           = 8'h00,
        op_bipush        = 8'h10,
        op_pop           = 8'h57,
        op_dup           = 8'h59,
        op_iadd          = 8'h60,
        op_isub          = 8'h64,
        op_ifeq          = 8'h99,
        op_ifne          = 8'h9a,
        op_iflt          = 8'h9b,
        op_if_icmpeq     = 8'h9f,
        op_if_icmplt     = 8'ha1,
        op_goto          = 8'ha7,
        op_return        = 8'hb1,
        op_invokevirtual = 8'hb6,
        op_donext        = 8'hca,
        op_pushr         = 8'hcb,
        op_popr          = 8'hcc,
        op_dupr          = 8'hcd
    } opcode_t;

    // total bytes incl. opcode, unknown bytes count as nop
    function automatic logic [1:0] op_len(input opcode_t op);
        case (op)
        op_bipush: return 2'd2;
        op_ifeq, op_ifne, op_iflt, op_if_icmpeq, op_if_icmplt,
        op_goto, op_invokevirtual, op_donext: return 2'd3;  // 16-bit target
        default: return 2'd1;
        endcase
    endfunction

endpackage

// File: common/ej_config.svh
// ==============================
// core sizes: data width, program
// address width, stack depths
// ==============================
`ifndef EJ_CONFIG_SVH
`define EJ_CONFIG_SVH

`define DSZ      32    // data path width
`define ASZ      12    // program address width, 4 KB
`define DS_DEPTH 16    // data stack entries below TOS
`define RS_DEPTH 16    // return stack entries

`endif
